/* logic/cache_pkg.sv */
package cache_pkg;

    // address split: tag | set index | byte offset
    localparam int tag_width    = 9;
    localparam int index_width  = 3;
    localparam int offset_width = 4;

    localparam int addr_width = tag_width + index_width + offset_width;

    // sets per way
    localparam int num_sets = 2 ** index_width;

    // bytes in one line
    localparam int line_bytes = 2 ** offset_width;

    // byte address on the cpu and memory side
    typedef logic [addr_width-1:0] addr_t;

    // stored line tag
    typedef logic [tag_width-1:0] tag_t;

    // set index
    typedef logic [index_width-1:0] index_t;

    // one full cache line
    typedef logic [8*line_bytes-1:0] line_t;

    // one write enable per byte of a line
    typedef logic [line_bytes-1:0] byte_mask_t;

endpackage

/* logic/cache_ctrl_if.sv */
`timescale 1ns/1ps

interface cache_ctrl_if;

    // controller to datapath
    logic way_sel;
    logic data_source_sel;
    logic tag_bypass_sel;
    logic load;
    logic load_lru;

    // datapath to controller
    logic hit_0;
    logic hit_1;
    logic dirty;
    logic lru;

    modport control (
        output way_sel, data_source_sel, tag_bypass_sel, load, load_lru,
        input  hit_0, hit_1, dirty, lru
    );

    modport datapath (
        input  way_sel, data_source_sel, tag_bypass_sel, load, load_lru,
        output hit_0, hit_1, dirty, lru
    );

endinterface

/* logic/cache_way.sv */
`timescale 1ns/1ps

module cache_way import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       load,
    input  logic       fill,
    input  byte_mask_t byte_mask,
    input  tag_t       tag_in,
    input  index_t     index,
    input  line_t      data_in,
    output tag_t       tag_out,
    output line_t      data_out,
    output logic       dirty,
    output logic       hit
);

    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;
    tag_t                tag_arr  [num_sets];
    line_t               line_arr [num_sets];

    // status bits of each set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (load) begin
            valid_bits[index] <= 1'b1;
            // a fill brings the line in clean, a cpu write dirties it
            dirty_bits[index] <= ~fill;
        end
    end

    // tag and line storage
    always_ff @(posedge clk) begin
        if (load) begin
            tag_arr[index] <= tag_in;
            for (int b = 0; b < line_bytes; b++) begin
                if (byte_mask[b]) begin
                    line_arr[index][8*b +: 8] <= data_in[8*b +: 8];
                end
            end
        end
    end

    // combinational read of the indexed set
    assign tag_out  = tag_arr[index];
    assign data_out = line_arr[index];
    assign dirty    = dirty_bits[index];
    assign hit      = valid_bits[index] && (tag_arr[index] == tag_in);

endmodule

/* logic/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    cache_ctrl_if.datapath ctrl,
    input  addr_t      cpu_addr,
    input  byte_mask_t cpu_byte_mask,
    input  line_t      cpu_wdata,
    input  line_t      pmem_rdata,
    output line_t      cpu_rdata,
    output addr_t      pmem_addr,
    output line_t      pmem_wdata
);

    tag_t       req_tag;
    index_t     index;
    line_t      data_in;
    byte_mask_t byte_mask;
    logic [1:0] way_load;
    logic [1:0] way_hit;
    logic [1:0] way_dirty;
    tag_t       way_tag  [2];
    line_t      way_data [2];
    line_t      sel_data;
    tag_t       sel_tag;
    tag_t       addr_tag;

    logic [num_sets-1:0] lru_bits;

    // request address split
    assign req_tag = cpu_addr[addr_width-1 -: tag_width];
    assign index   = cpu_addr[offset_width +: index_width];

    // input steering, memory fills always write every byte
    assign data_in   = ctrl.data_source_sel ? pmem_rdata : cpu_wdata;
    assign byte_mask = ctrl.data_source_sel ? '1 : cpu_byte_mask;

    // load goes only to the selected way
    assign way_load[0] = ctrl.load & ~ctrl.way_sel;
    assign way_load[1] = ctrl.load &  ctrl.way_sel;

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_way u_cache_way (
            .clk       (clk),
            .arst_n    (arst_n),
            .load      (way_load[w]),
            .fill      (ctrl.data_source_sel),
            .byte_mask (byte_mask),
            .tag_in    (req_tag),
            .index     (index),
            .data_in   (data_in),
            .tag_out   (way_tag[w]),
            .data_out  (way_data[w]),
            .dirty     (way_dirty[w]),
            .hit       (way_hit[w])
        );
    end

    // output steering by the selected way
    assign sel_data   = ctrl.way_sel ? way_data[1] : way_data[0];
    assign sel_tag    = ctrl.way_sel ? way_tag[1] : way_tag[0];
    assign cpu_rdata  = sel_data;
    assign pmem_wdata = sel_data;

    // victim tag for write-back, request tag for fill
    assign addr_tag  = ctrl.tag_bypass_sel ? req_tag : sel_tag;
    assign pmem_addr = {addr_tag, index, {offset_width{1'b0}}};

    // one lru bit per set, names the way to replace next
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bits <= '0;
        end else if (ctrl.load_lru) begin
            lru_bits[index] <= ~ctrl.way_sel;
        end
    end

    assign ctrl.lru   = lru_bits[index];
    assign ctrl.dirty = lru_bits[index] ? way_dirty[1] : way_dirty[0];
    assign ctrl.hit_0 = way_hit[0];
    assign ctrl.hit_1 = way_hit[1];

endmodule

/* logic/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
    input  logic clk,
    input  logic arst_n,
    cache_ctrl_if.control ctrl,
    input  logic cpu_read,
    input  logic cpu_write,
    input  logic pmem_resp,
    output logic cpu_resp,
    output logic pmem_read,
    output logic pmem_write
);

    typedef enum logic [1:0] {
        state_idle,
        state_write_back,
        state_fill
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        request;
    logic        hit;

    assign request = cpu_read | cpu_write;
    assign hit     = ctrl.hit_0 | ctrl.hit_1;

    // state register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= state_idle;
        end else begin
            state <= state_next;
        end
    end

    // next state and outputs
    always_comb begin
        state_next           = state;
        ctrl.way_sel         = 1'b0;
        ctrl.data_source_sel = 1'b0;
        ctrl.tag_bypass_sel  = 1'b0;
        ctrl.load            = 1'b0;
        ctrl.load_lru        = 1'b0;
        cpu_resp             = 1'b0;
        pmem_read            = 1'b0;
        pmem_write           = 1'b0;

        case (state)
            state_idle: begin
                if (request) begin
                    if (hit) begin
                        // answer in the same cycle, write merges cpu bytes
                        ctrl.way_sel  = ctrl.hit_1;
                        ctrl.load_lru = 1'b1;
                        ctrl.load     = cpu_write;
                        cpu_resp      = 1'b1;
                    end else begin
                        // miss, replace the lru way
                        ctrl.way_sel = ctrl.lru;
                        if (ctrl.dirty) begin
                            state_next = state_write_back;
                        end else begin
                            state_next = state_fill;
                        end
                    end
                end
            end

            state_write_back: begin
                // victim tag and line go out to memory
                ctrl.way_sel = ctrl.lru;
                pmem_write   = 1'b1;
                if (pmem_resp) begin
                    state_next = state_fill;
                end
            end

            state_fill: begin
                ctrl.way_sel         = ctrl.lru;
                ctrl.tag_bypass_sel  = 1'b1;
                ctrl.data_source_sel = 1'b1;
                pmem_read            = 1'b1;
                if (pmem_resp) begin
                    // line lands clean, request then hits from idle
                    ctrl.load  = 1'b1;
                    state_next = state_idle;
                end
            end

            default: begin
                state_next = state_idle;
            end
        endcase
    end

endmodule

/* logic/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    // cpu side
    input  logic       cpu_read,
    input  logic       cpu_write,
    input  addr_t      cpu_addr,
    input  byte_mask_t cpu_byte_mask,
    input  line_t      cpu_wdata,
    output line_t      cpu_rdata,
    output logic       cpu_resp,

    // memory side
    input  line_t      pmem_rdata,
    input  logic       pmem_resp,
    output addr_t      pmem_addr,
    output line_t      pmem_wdata,
    output logic       pmem_read,
    output logic       pmem_write
);

    cache_ctrl_if ctrl_if ();

    cache_control u_cache_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl_if.control),
        .cpu_read   (cpu_read),
        .cpu_write  (cpu_write),
        .pmem_resp  (pmem_resp),
        .cpu_resp   (cpu_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write)
    );

    cache_datapath u_cache_datapath (
        .clk           (clk),
        .arst_n        (arst_n),
        .ctrl          (ctrl_if.datapath),
        .cpu_addr      (cpu_addr),
        .cpu_byte_mask (cpu_byte_mask),
        .cpu_wdata     (cpu_wdata),
        .pmem_rdata    (pmem_rdata),
        .cpu_rdata     (cpu_rdata),
        .pmem_addr     (pmem_addr),
        .pmem_wdata    (pmem_wdata)
    );

endmodule

/* test/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cpu_read,
    input  logic       cpu_write,
    input  addr_t      cpu_addr,
    input  byte_mask_t cpu_byte_mask,
    input  line_t      cpu_wdata,
    input  line_t      cpu_rdata,
    input  logic       cpu_resp,
    input  addr_t      pmem_addr,
    input  line_t      pmem_wdata,
    input  logic       pmem_resp,
    input  logic       pmem_read,
    input  logic       pmem_write,
    input  logic       end_of_run,
    output int         total_checks,
    output int         total_errors
);

    localparam int num_lines = 2 ** (tag_width + index_width);

    // memory as the cpu sees it with byte merges applied
    line_t ref_mem [num_lines];
    bit    written [num_lines];

    // cache model per set and way
    tag_t  model_tag   [num_sets][2];
    bit    model_valid [num_sets][2];
    bit    model_dirty [num_sets][2];
    bit    model_lru   [num_sets];
    bit    set_seen    [num_sets];

    // request in flight and its predicted outcome
    bit    busy;
    bit    started;
    addr_t req_addr;
    bit    req_write;
    bit    req_hit;
    bit    victim;
    bit    victim_dirty;
    addr_t victim_addr;
    int    reads_seen;
    int    writes_seen;
    int    checks [5];
    int    errors [5];

    function automatic line_t line_pattern(input int line_index);
        line_t l;
        addr_t a;
        for (int b = 0; b < line_bytes; b++) begin
            a = addr_t'(line_index * line_bytes + b);
            l[8*b +: 8] = a[15:8] ^ (a[7:0] * 8'd29) ^ 8'h6b;
        end
        return l;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0: return "reset state";
            1: return "read data";
            2: return "hit and miss prediction";
            3: return "replacement and write-back";
            default: return "byte-masked writes";
        endcase
    endfunction

    task automatic expect_true(input int t, input logic ok, input string what);
        checks[t]++;
        if (!ok) begin
            errors[t]++;
            $display("%0t ns: %s", $time, what);
        end
    endtask

    task automatic check_value(input int t, input string name, input line_t expected,
                               input line_t actual);
        checks[t]++;
        if (expected !== actual) begin
            errors[t]++;
            $display("ERROR at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin : monitor
        tag_t   tag;
        index_t idx;
        bit     way;
        logic [tag_width+index_width-1:0] line;
        if (!started) begin
            expect_true(0, !cpu_resp && !pmem_read && !pmem_write,
                        "cache strobes active after reset before any request");
        end
        if (!arst_n) begin
            for (int i = 0; i < num_lines; i++) begin
                ref_mem[i] = line_pattern(i);
                written[i] = 1'b0;
            end
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < 2; w++) begin
                    model_valid[s][w] = 1'b0;
                    model_dirty[s][w] = 1'b0;
                end
                model_lru[s] = 1'b0;
                set_seen[s]  = 1'b0;
            end
            busy    = 1'b0;
            started = 1'b0;
        end else begin
            // predict hit, victim and write-back of a new request from the model
            if ((cpu_read || cpu_write) && !busy) begin
                busy         = 1'b1;
                started      = 1'b1;
                req_addr     = cpu_addr;
                req_write    = cpu_write;
                reads_seen   = 0;
                writes_seen  = 0;
                tag          = cpu_addr[addr_width-1 -: tag_width];
                idx          = cpu_addr[offset_width +: index_width];
                req_hit      = (model_valid[idx][0] && model_tag[idx][0] == tag) ||
                               (model_valid[idx][1] && model_tag[idx][1] == tag);
                victim       = model_lru[idx];
                victim_dirty = model_valid[idx][victim] && model_dirty[idx][victim];
                victim_addr  = {model_tag[idx][victim], idx, {offset_width{1'b0}}};
            end
            tag  = req_addr[addr_width-1 -: tag_width];
            idx  = req_addr[offset_width +: index_width];
            line = req_addr[addr_width-1:offset_width];
            if (pmem_resp && pmem_write) begin
                writes_seen++;
                expect_true(3, busy && !req_hit && victim_dirty,
                            "memory write with no dirty victim to write back");
                if (busy && !req_hit && victim_dirty) begin
                    check_value(3, "pmem_addr", line_t'(victim_addr), line_t'(pmem_addr));
                    check_value(3, "pmem_wdata",
                                ref_mem[victim_addr[addr_width-1:offset_width]], pmem_wdata);
                end
            end
            if (pmem_resp && pmem_read) begin
                reads_seen++;
                expect_true(2, busy && !req_hit, "line fetched with no predicted miss");
                check_value(2, "pmem_addr", line_t'({line, {offset_width{1'b0}}}),
                            line_t'(pmem_addr));
                expect_true(3, !victim_dirty || writes_seen == 1,
                            "line fetched before the dirty victim was written back");
            end
            if (cpu_resp) begin
                expect_true(2, busy, "cpu_resp with no request pending");
                if (!set_seen[idx]) begin
                    expect_true(0, reads_seen == 1 && writes_seen == 0,
                                "first access to a set did not fetch its line cleanly");
                    set_seen[idx] = 1'b1;
                end
                if (req_hit) begin
                    expect_true(2, reads_seen == 0 && writes_seen == 0,
                                "memory traffic on a predicted hit");
                end else begin
                    expect_true(2, reads_seen == 1, "predicted miss did not fetch exactly one line");
                end
                expect_true(3, writes_seen == ((!req_hit && victim_dirty) ? 1 : 0),
                            "write-back count does not match the victim's dirty bit");
                if (!req_write) begin
                    check_value(written[line] ? 4 : 1, "cpu_rdata", ref_mem[line], cpu_rdata);
                end else begin
                    for (int b = 0; b < line_bytes; b++) begin
                        if (cpu_byte_mask[b]) begin
                            ref_mem[line][8*b +: 8] = cpu_wdata[8*b +: 8];
                        end
                    end
                    written[line] = 1'b1;
                end
                // a miss refills the victim clean and the access then hits
                if (!req_hit) begin
                    model_tag[idx][victim]   = tag;
                    model_valid[idx][victim] = 1'b1;
                    model_dirty[idx][victim] = 1'b0;
                end
                way            = model_valid[idx][1] && model_tag[idx][1] == tag;
                model_lru[idx] = ~way;
                if (req_write) begin
                    model_dirty[idx][way] = 1'b1;
                end
                busy = 1'b0;
            end
        end
    end

    initial begin : summary
        total_checks = 0;
        total_errors = 0;
        wait (end_of_run);
        for (int t = 0; t < 5; t++) begin
            $display("test %0d, %s: %0d checks, %0d errors",
                     t + 1, test_name(t), checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
    end

endmodule

/* test/tb_l1_cache.sv */
`timescale 1ns/1ps

module tb_l1_cache import cache_pkg::*; ();

    localparam int num_lines      = 2 ** (tag_width + index_width);
    localparam int num_random     = 600;
    localparam int worst_cycles   = 16;
    localparam int timeout_cycles = (num_sets + num_random) * worst_cycles + 100;
    localparam int seed_init      = 32'h51d8_7bd3;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       cpu_read;
    logic       cpu_write;
    addr_t      cpu_addr;
    byte_mask_t cpu_byte_mask;
    line_t      cpu_wdata;
    line_t      cpu_rdata;
    logic       cpu_resp;
    line_t      pmem_rdata;
    logic       pmem_resp;
    addr_t      pmem_addr;
    line_t      pmem_wdata;
    logic       pmem_read;
    logic       pmem_write;
    logic       end_of_run;
    int         total_checks;
    int         total_errors;
    integer     seed;
    integer     mem_seed;
    line_t      mem [num_lines];

    l1_cache u_l1_cache (.*);

    cache_checker u_cache_checker (.*);

    always #20 clk = ~clk;

    // each byte is derived from its full byte address
    function automatic line_t line_pattern(input int line_index);
        line_t l;
        addr_t a;
        for (int b = 0; b < line_bytes; b++) begin
            a = addr_t'(line_index * line_bytes + b);
            l[8*b +: 8] = a[15:8] ^ (a[7:0] * 8'd29) ^ 8'h6b;
        end
        return l;
    endfunction

    // a few tags only, so that sets conflict and evict often
    function automatic tag_t pool_tag(input logic [1:0] sel);
        case (sel)
            2'd0: return 9'h000;
            2'd1: return 9'h0a5;
            2'd2: return 9'h13c;
            default: return 9'h1ff;
        endcase
    endfunction

    function automatic line_t random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // hold one request until the cache answers
    task automatic run_request(input logic is_write, input addr_t addr,
                               input byte_mask_t mask, input line_t data);
        cpu_read      <= ~is_write;
        cpu_write     <= is_write;
        cpu_addr      <= addr;
        cpu_byte_mask <= mask;
        cpu_wdata     <= data;
        @(posedge clk);
        while (!cpu_resp) begin
            @(posedge clk);
        end
    endtask

    initial begin : stimulus
        int         rnd;
        byte_mask_t mask;
        seed          = seed_init;
        arst_n        = 1'b0;
        cpu_read      = 1'b0;
        cpu_write     = 1'b0;
        cpu_addr      = '0;
        cpu_byte_mask = '0;
        cpu_wdata     = '0;
        end_of_run    = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        // one read into every set first
        for (int s = 0; s < num_sets; s++) begin
            rnd = $random(seed);
            run_request(1'b0, {pool_tag(rnd[1:0]), index_t'(s), rnd[7:4]}, '1, '0);
        end
        for (int n = 0; n < num_random; n++) begin
            rnd = $random(seed);
            case (rnd[8:6])
                3'd0: mask = '0;
                3'd1: mask = '1;
                default: mask = rnd[31:16];
            endcase
            run_request(rnd[0], {pool_tag(rnd[2:1]), rnd[5:3], rnd[12:9]}, mask, random_line());
            if (rnd[13]) begin
                cpu_read  <= 1'b0;
                cpu_write <= 1'b0;
                @(posedge clk);
            end
        end
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;
        @(posedge clk);
        end_of_run <= 1'b1;
        repeat (2) @(posedge clk);
        $display("requests %0d, checks %0d, errors %0d",
                 num_sets + num_random, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // line memory, answers 1 to 4 cycles after a request shows up
    initial begin : memory_model
        int wait_left;
        int rnd;
        wait_left  = -1;
        mem_seed   = seed_init;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        for (int i = 0; i < num_lines; i++) begin
            mem[i] = line_pattern(i);
        end
        forever begin
            @(posedge clk);
            if (pmem_resp) begin
                pmem_resp <= 1'b0;
            end else if (arst_n && (pmem_read || pmem_write)) begin
                if (wait_left < 0) begin
                    rnd       = $random(mem_seed);
                    wait_left = rnd & 3;
                end
                if (wait_left == 0) begin
                    if (pmem_read) begin
                        pmem_rdata <= mem[pmem_addr[addr_width-1:offset_width]];
                    end else begin
                        mem[pmem_addr[addr_width-1:offset_width]] = pmem_wdata;
                    end
                    pmem_resp <= 1'b1;
                end
                wait_left = wait_left - 1;
            end
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("simulation hung, no end of run after %0d cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* l1_cache.f */
logic/cache_pkg.sv
logic/cache_ctrl_if.sv
logic/cache_way.sv
logic/cache_datapath.sv
logic/cache_control.sv
logic/l1_cache.sv
test/cache_checker.sv
test/tb_l1_cache.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_l1_cache -f l1_cache.f
./obj_dir/Vtb_l1_cache > sim.log 2>&1
cat sim.log

if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
